//--- clic_sub.f
common/clic_types_pkg.sv
common/clic_regmap_pkg.sv
hdl/clic_reg_port.sv
hdl/clic_gateway.sv
clic_arbiter/clic_ctl_decode.sv
clic_arbiter/clic_max_select.sv
hdl/clic_top.sv
verif/clic_assertions.sv
verif/clic_checker.sv
verif/tb_clic.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f clic_sub.f --top-module tb_clic --Mdir obj_dir
./obj_dir/Vtb_clic | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
  exit 0
else
  exit 1
fi

//--- verif/tb_clic.sv
`timescale 1ns/10ps

module tb_clic
  import clic_types_pkg::*;
  import clic_regmap_pkg::*;
();

  localparam int num_irq  = 16;
  localparam int ctl_bits = 4;
  localparam int max_rows = 32;
  localparam int max_wr   = 6;
  localparam int chk_irq  = 0;
  localparam int chk_read = 1;
  localparam int chk_none = 2;

  logic      clk;
  logic      rst;
  logic      valid;
  bus_addr_t addr;
  bus_word_t wdata;
  wstrb_t    wstrb;
  logic      irq [num_irq];
  bus_word_t rdata;
  logic      ready;
  logic      meip;
  irq_id_t   meid;
  int        pass_count;
  int        fail_count;
  int        cycles = 0;
  int        timeout_cycles;
  int        n_rows = 0;

  // one entry per test.
  string       row_name [max_rows];
  int          row_kind [max_rows];
  logic [15:0] row_irq [max_rows];
  logic        row_meip [max_rows];
  int          row_meid [max_rows];
  bus_addr_t   row_req_addr [max_rows];
  wstrb_t      row_req_strb [max_rows];
  bus_word_t   row_rdata [max_rows];
  int          row_nwr [max_rows];
  bus_addr_t   wr_addr [max_rows][max_wr];
  bus_word_t   wr_data [max_rows][max_wr];
  wstrb_t      wr_strb [max_rows][max_wr];

  clic_top #(.num_irq(num_irq), .ctl_bits(ctl_bits)) clic_top_i (
    .clk, .rst, .valid, .addr, .wdata, .wstrb, .irq, .rdata, .ready, .meip, .meid
  );

  clic_checker chk_i (
    .clk, .ready, .rdata, .meip, .meid, .pass_count, .fail_count
  );

  bind clic_top clic_assertions assert_i (
    .clk, .rst, .valid, .ready, .rdata, .meip, .meid
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic bus_addr_t int_addr(input int i);
    return int_base + bus_addr_t'(4 * i);
  endfunction

  function automatic void add_row(input string name, input int kind, input logic [15:0] pat,
                                  input logic exp_meip, input int exp_meid);
    row_name[n_rows]     = name;
    row_kind[n_rows]     = kind;
    row_irq[n_rows]      = pat;
    row_meip[n_rows]     = exp_meip;
    row_meid[n_rows]     = exp_meid;
    row_req_addr[n_rows] = '0;
    row_req_strb[n_rows] = '0;
    row_rdata[n_rows]    = '0;
    row_nwr[n_rows]      = 0;
    n_rows++;
  endfunction

  function automatic void add_write(input bus_addr_t a, input bus_word_t d, input wstrb_t s);
    int r;
    r = n_rows - 1;
    wr_addr[r][row_nwr[r]] = a;
    wr_data[r][row_nwr[r]] = d;
    wr_strb[r][row_nwr[r]] = s;
    row_nwr[r]++;
  endfunction

  function automatic void add_req(input bus_addr_t a, input wstrb_t s, input bus_word_t exp);
    row_req_addr[n_rows - 1] = a;
    row_req_strb[n_rows - 1] = s;
    row_rdata[n_rows - 1]    = exp;
  endfunction

  // level from the top min(nlbits, ctl_bits) bits, priority from the rest, ones below.
  function automatic logic [15:0] rank_of(input logic [7:0] c, input int nlb);
    int         n;
    logic [7:0] lvl;
    logic [7:0] pri;
    n   = (nlb < ctl_bits) ? nlb : ctl_bits;
    lvl = 8'hff;
    pri = 8'hff;
    for (int b = 0; b < n; b++) begin
      lvl[7 - b] = c[7 - b];
    end
    for (int b = 0; b < ctl_bits - n; b++) begin
      pri[7 - b] = c[7 - n - b];
    end
    return {lvl, pri};
  endfunction

  function automatic void add_rand_row(input string name, input int nlb);
    logic [7:0]  c;
    logic [15:0] rank;
    logic [15:0] best;
    int          best_id;
    best    = '0;
    best_id = 0;
    add_row(name, chk_irq, 16'hf000, 1'b1, 0);
    add_write(cfg_addr, bus_word_t'(nlb) << cfg_nlbits_lsb, 4'b0001);
    for (int i = 12; i < num_irq; i++) begin
      c = 8'($urandom);
      add_write(int_addr(i), {c, 8'h00, 8'h01, 8'h00}, 4'b1010);
      rank = rank_of(c, nlb);
      // strict compare keeps the lowest ID on a tie.
      if (rank > best) begin
        best    = rank;
        best_id = i;
      end
    end
    row_meid[n_rows - 1] = best_id;
  endfunction

  task automatic bus_req(input bus_addr_t a, input bus_word_t d, input wstrb_t s);
    valid = 1'b1;
    addr  = a;
    wdata = d;
    wstrb = s;
    @(negedge clk);
    valid = 1'b0;
    addr  = '0;
    wdata = '0;
    wstrb = '0;
  endtask

  task automatic apply_row(input int r);
    for (int i = 0; i < num_irq; i++) begin
      irq[i] = row_irq[r][i];
    end
    for (int w = 0; w < row_nwr[r]; w++) begin
      bus_req(wr_addr[r][w], wr_data[r][w], wr_strb[r][w]);
    end
    if (row_kind[r] != chk_irq) begin
      bus_req(row_req_addr[r], '0, row_req_strb[r]);
    end
    chk_i.check_row(row_name[r], row_kind[r], row_meip[r], row_meid[r], row_rdata[r]);
    @(negedge clk);
  endtask

  initial begin
    void'($urandom(32'h12dd));
    rst   = 1'b0;
    valid = 1'b0;
    addr  = '0;
    wdata = '0;
    wstrb = '0;
    for (int i = 0; i < num_irq; i++) begin
      irq[i] = 1'b0;
    end
    add_row("info_word", chk_read, 16'h0000, 1'b0, 0);
    add_req(info_addr, 4'b0000,
            (bus_word_t'(ctl_bits) << info_ctlbits_lsb) | bus_word_t'(num_irq));
    add_row("ctl_readback", chk_read, 16'h0000, 1'b0, 0);
    add_write(int_addr(3), 32'ha500_0000, 4'b1000);
    add_req(int_addr(3), 4'b0000, 32'haf00_0000);
    add_row("ie_strobe_only", chk_read, 16'h0000, 1'b0, 0);
    add_write(int_addr(3), 32'hffff_ffff, 4'b0010);
    add_req(int_addr(3), 4'b0000, 32'haf00_0100);
    // byte 2 sets shv and the rising-edge mode.
    add_row("attr_strobe_only", chk_read, 16'h0000, 1'b0, 0);
    add_write(int_addr(3), 32'h5503_aa01, 4'b0100);
    add_req(int_addr(3), 4'b0000, 32'haf03_0100);
    add_row("level_follow", chk_irq, 16'h0020, 1'b1, 5);
    add_write(int_addr(5), 32'h0000_0100, 4'b0010);
    add_row("level_release", chk_irq, 16'h0000, 1'b0, 0);
    add_row("level_masked_by_ie", chk_irq, 16'h0040, 1'b0, 0);
    add_row("pos_edge_latch", chk_irq, 16'h0008, 1'b1, 3);
    add_row("pos_edge_held", chk_irq, 16'h0000, 1'b1, 3);
    add_row("sw_clear_pos_edge", chk_irq, 16'h0000, 1'b0, 0);
    add_write(int_addr(3), 32'h0000_0000, 4'b0001);
    add_row("neg_edge_config", chk_irq, 16'h0000, 1'b0, 0);
    add_write(int_addr(7), 32'h0006_0100, 4'b0110);
    add_row("neg_edge_rise_ignored", chk_irq, 16'h0080, 1'b0, 0);
    add_row("neg_edge_latch", chk_irq, 16'h0000, 1'b1, 7);
    add_row("sw_clear_neg_edge", chk_irq, 16'h0000, 1'b0, 0);
    add_write(int_addr(7), 32'h0000_0000, 4'b0001);
    // the read right after the clear still sees the pin.
    add_row("sw_write_level_ignored", chk_read, 16'h0020, 1'b0, 0);
    add_write(int_addr(5), 32'h0000_0000, 4'b0001);
    add_req(int_addr(5), 4'b0000, 32'h0f00_0101);
    // two level bits from here on.
    add_row("level_beats_prio", chk_irq, 16'h0300, 1'b1, 9);
    add_write(cfg_addr, 32'h0000_0004, 4'b0001);
    add_write(int_addr(8), 32'h7000_0100, 4'b1010);
    add_write(int_addr(9), 32'h8000_0100, 4'b1010);
    add_row("prio_breaks_level_tie", chk_irq, 16'h0700, 1'b1, 10);
    add_write(int_addr(10), 32'h9000_0100, 4'b1010);
    add_row("full_tie_lowest_id", chk_irq, 16'h0f00, 1'b1, 10);
    add_write(int_addr(11), 32'h9000_0100, 4'b1010);
    add_row("id0_ignored", chk_irq, 16'h0401, 1'b1, 10);
    add_write(int_addr(0), 32'hf000_0100, 4'b1010);
    add_row("id0_alone", chk_irq, 16'h0001, 1'b0, 0);
    add_rand_row("random_nlbits_0", 0);
    add_rand_row("random_nlbits_2", 2);
    add_rand_row("random_nlbits_max", ctl_bits);
    add_row("unmapped_read", chk_none, 16'h0000, 1'b0, 0);
    add_req(32'h0000_0008, 4'b0000, '0);
    add_row("unmapped_write", chk_none, 16'h0000, 1'b0, 0);
    add_req(int_addr(num_irq), 4'b1111, '0);
    timeout_cycles = n_rows * 40;

    repeat (8) @(negedge clk);
    rst = 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      apply_row(r);
    end
    $display("summary: %0d passed, %0d failed, %0d assertion failures",
             pass_count, fail_count, clic_top_i.assert_i.fail_cnt);
    if ((fail_count == 0) && (clic_top_i.assert_i.fail_cnt == 0)) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verif/clic_checker.sv
`timescale 1ns/10ps

module clic_checker
  import clic_types_pkg::*;
(
  input  logic      clk,
  input  logic      ready,
  input  bus_word_t rdata,
  input  logic      meip,
  input  irq_id_t   meid,
  output int        pass_count,
  output int        fail_count
);

  int passes = 0;
  int fails  = 0;

  assign pass_count = passes;
  assign fail_count = fails;

  // kind 0 checks meip and meid, kind 1 a read response, kind 2 expects no response.
  task automatic check_row(input string name, input int kind, input logic exp_meip,
                           input int exp_meid, input bus_word_t exp_rdata);
    int errs;
    errs = 0;
    if (kind == 0) begin
      // well past the three-cycle pin to meid latency.
      repeat (5) @(negedge clk);
      if (meip !== exp_meip) begin
        $display("** Error at %0t: %s: meip expected %0b, got %0b", $time, name, exp_meip, meip);
        errs++;
      end
      if (meid !== irq_id_t'(exp_meid)) begin
        $display("** Error at %0t: %s: meid expected %0d, got %0d", $time, name, exp_meid, meid);
        errs++;
      end
    end else begin
      if ((kind == 1) && (ready !== 1'b1)) begin
        $display("%s: the read got no ready one cycle after valid", name);
        errs++;
      end else if ((kind == 1) && (rdata !== exp_rdata)) begin
        $display("** Error at %0t: %s: rdata expected %08h, got %08h", $time, name,
                 exp_rdata, rdata);
        errs++;
      end else if ((kind == 2) && (ready !== 1'b0)) begin
        $display("%s: a request outside the map got a ready", name);
        errs++;
      end
      @(negedge clk);
      if (ready !== 1'b0) begin
        $display("%s: ready stayed high for more than one cycle", name);
        errs++;
      end
    end
    if (errs == 0) begin
      passes++;
      $display("ok   %s", name);
    end else begin
      fails++;
      $display("fail %s (%0d mismatches)", name, errs);
    end
  endtask

endmodule

//--- verif/clic_assertions.sv
`timescale 1ns/10ps

module clic_assertions
  import clic_types_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      valid,
  input logic      ready,
  input bus_word_t rdata,
  input logic      meip,
  input irq_id_t   meid
);

  int fail_cnt = 0;

  // a response always follows a request.
  ready_after_valid: assert property (@(posedge clk) disable iff (!rst) ready |-> $past(valid))
    else begin
      fail_cnt++;
      $error("ready without a request in the cycle before");
    end

  rdata_idle_zero: assert property (@(posedge clk) disable iff (!rst) !ready |-> rdata == '0)
    else begin
      fail_cnt++;
      $error("rdata nonzero outside a ready cycle");
    end

  // meid is zero exactly when there is no request.
  meid_matches_meip: assert property (@(posedge clk) disable iff (!rst) meip == (meid != '0))
    else begin
      fail_cnt++;
      $error("meip and meid disagree");
    end

endmodule

//--- hdl/clic_top.sv
`timescale 1ns/10ps

module clic_top
  import clic_types_pkg::*;
#(
  parameter int num_irq  = 16,
  parameter int ctl_bits = 4
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      valid,
  input  bus_addr_t addr,
  input  bus_word_t wdata,
  input  wstrb_t    wstrb,
  input  logic      irq [num_irq],
  output bus_word_t rdata,
  output logic      ready,
  output logic      meip,
  output irq_id_t   meid
);

  logic       ip [num_irq];
  logic       ie [num_irq];
  trig_mode_t trig [num_irq];
  ctl_t       ctl [num_irq];
  nlbits_t    nlbits;
  logic       sw_ip_we [num_irq];
  logic       sw_ip_val;
  level_t     level_e [num_irq];
  prio_t      prio_e [num_irq];

  clic_reg_port #(.num_irq(num_irq), .ctl_bits(ctl_bits)) u_reg_port (
    .clk, .rst, .valid, .addr, .wdata, .wstrb, .ip,
    .rdata, .ready, .ie, .trig, .ctl, .nlbits, .sw_ip_we, .sw_ip_val
  );

  clic_gateway #(.num_irq(num_irq)) u_gateway (
    .clk, .rst, .irq, .trig, .sw_ip_we, .sw_ip_val, .ip
  );

  clic_ctl_decode #(.num_irq(num_irq), .ctl_bits(ctl_bits)) u_ctl_decode (
    .clk, .rst, .ctl, .nlbits, .ip, .ie, .level_e, .prio_e
  );

  clic_max_select #(.num_irq(num_irq)) u_max_select (
    .clk, .rst, .level_e, .prio_e, .meip, .meid
  );

endmodule

//--- clic_arbiter/clic_max_select.sv
`timescale 1ns/10ps

module clic_max_select
  import clic_types_pkg::*;
#(
  parameter int num_irq = 16
) (
  input  logic    clk,
  input  logic    rst,
  input  level_t  level_e [num_irq],
  input  prio_t   prio_e [num_irq],
  output logic    meip,
  output irq_id_t meid
);

  irq_id_t best_id;
  level_t  best_level;
  prio_t   best_prio;
  logic    better;

  // ID 0 never competes.
  // strict compares keep the lowest ID on a full tie.
  always_comb begin
    best_id    = '0;
    best_level = '0;
    best_prio  = '0;
    better     = 1'b0;
    for (int i = 1; i < num_irq; i++) begin
      better = (level_e[i] > best_level) ||
               ((level_e[i] == best_level) && (prio_e[i] > best_prio));
      if ((level_e[i] != '0) && better) begin
        best_id    = irq_id_t'(i);
        best_level = level_e[i];
        best_prio  = prio_e[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      meip <= 1'b0;
      meid <= '0;
    end else begin
      meip <= (best_level != '0);
      meid <= best_id;
    end
  end

endmodule

//--- clic_arbiter/clic_ctl_decode.sv
`timescale 1ns/10ps

module clic_ctl_decode
  import clic_types_pkg::*;
#(
  parameter int num_irq  = 16,
  parameter int ctl_bits = 4
) (
  input  logic    clk,
  input  logic    rst,
  input  ctl_t    ctl [num_irq],
  input  nlbits_t nlbits,
  input  logic    ip [num_irq],
  input  logic    ie [num_irq],
  output level_t  level_e [num_irq],
  output prio_t   prio_e [num_irq]
);

  logic [3:0] n_lvl;
  logic [3:0] n_pri;
  level_t     level_w [num_irq];
  prio_t      prio_w [num_irq];

  // level bits are capped at the implemented width.
  assign n_lvl = (nlbits > 4'(ctl_bits)) ? 4'(ctl_bits) : nlbits;
  assign n_pri = 4'(ctl_bits) - n_lvl;

  always_comb begin
    for (int i = 0; i < num_irq; i++) begin
      level_w[i] = ctl[i] | (8'hff >> n_lvl);
      // remaining bits shifted to the top, ones below.
      prio_w[i]  = (ctl[i] << n_lvl) | (8'hff >> n_pri);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < num_irq; i++) begin
        level_e[i] <= '0;
        prio_e[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < num_irq; i++) begin
        level_e[i] <= (ip[i] && ie[i]) ? level_w[i] : '0;
        prio_e[i]  <= (ip[i] && ie[i]) ? prio_w[i] : '0;
      end
    end
  end

endmodule

//--- hdl/clic_gateway.sv
`timescale 1ns/10ps

module clic_gateway
  import clic_types_pkg::*;
#(
  parameter int num_irq = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       irq [num_irq],
  input  trig_mode_t trig [num_irq],
  input  logic       sw_ip_we [num_irq],
  input  logic       sw_ip_val,
  output logic       ip [num_irq]
);

  logic irq_q [num_irq];
  logic rise [num_irq];
  logic fall [num_irq];

  // edges against the previous sample.
  always_comb begin
    for (int i = 0; i < num_irq; i++) begin
      rise[i] = irq[i] && !irq_q[i];
      fall[i] = !irq[i] && irq_q[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < num_irq; i++) begin
        irq_q[i] <= 1'b0;
        ip[i]    <= 1'b0;
      end
    end else begin
      for (int i = 0; i < num_irq; i++) begin
        irq_q[i] <= irq[i];
        case (trig[i])
          trig_pos_edge: begin
            if (rise[i]) begin
              ip[i] <= 1'b1;
            end else if (sw_ip_we[i]) begin
              ip[i] <= sw_ip_val;
            end
          end
          trig_neg_edge: begin
            if (fall[i]) begin
              ip[i] <= 1'b1;
            end else if (sw_ip_we[i]) begin
              ip[i] <= sw_ip_val;
            end
          end
          // level mode, also for the unused encoding.
          default: ip[i] <= irq[i];
        endcase
      end
    end
  end

endmodule

//--- hdl/clic_reg_port.sv
`timescale 1ns/10ps

module clic_reg_port
  import clic_types_pkg::*;
  import clic_regmap_pkg::*;
#(
  parameter int num_irq  = 16,
  parameter int ctl_bits = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       valid,
  input  bus_addr_t  addr,
  input  bus_word_t  wdata,
  input  wstrb_t     wstrb,
  input  logic       ip [num_irq],
  output bus_word_t  rdata,
  output logic       ready,
  output logic       ie [num_irq],
  output trig_mode_t trig [num_irq],
  output ctl_t       ctl [num_irq],
  output nlbits_t    nlbits,
  output logic       sw_ip_we [num_irq],
  output logic       sw_ip_val
);

  localparam int idx_w = (num_irq > 1) ? $clog2(num_irq) : 1;
  // unimplemented low control bits read as one.
  localparam ctl_t ctl_fill = ctl_t'(8'hff >> ctl_bits);

  logic             nvbits;
  logic [1:0]       nmbits;
  logic             shv [num_irq];
  logic [1:0]       mode [num_irq];
  logic             is_read;
  logic             is_cfg;
  logic             is_info;
  logic             is_int;
  bus_addr_t        int_off;
  logic [idx_w-1:0] idx;
  bus_word_t        rd_word;

  assign is_read = (wstrb == '0);
  assign is_cfg  = ((addr >> 2) == (cfg_addr >> 2));
  assign is_info = ((addr >> 2) == (info_addr >> 2));
  assign is_int  = (addr >= int_base) && (addr < int_base + 32'(4 * num_irq));
  assign int_off = addr - int_base;
  assign idx     = int_off[idx_w+1:2];

  // byte 0 reaches the pending bit only on edge-triggered lines.
  always_comb begin
    for (int i = 0; i < num_irq; i++) begin
      sw_ip_we[i] = valid && is_int && !is_read && wstrb[0] && (idx == idx_w'(i)) &&
                    (trig[i] inside {trig_pos_edge, trig_neg_edge});
    end
  end

  assign sw_ip_val = wdata[ip_bit];

  always_comb begin
    rd_word = '0;
    if (is_cfg) begin
      rd_word[cfg_nvbits_bit]                 = nvbits;
      rd_word[cfg_nlbits_msb:cfg_nlbits_lsb]  = nlbits;
      rd_word[cfg_nmbits_msb:cfg_nmbits_lsb]  = nmbits;
    end else if (is_info) begin
      rd_word[info_ctlbits_msb:info_ctlbits_lsb] = 4'(ctl_bits);
      rd_word[info_numirq_msb:info_numirq_lsb]   = 13'(num_irq);
    end else if (is_int) begin
      rd_word[ip_bit]            = ip[idx];
      rd_word[ie_bit]            = ie[idx];
      rd_word[shv_bit]           = shv[idx];
      rd_word[trig_msb:trig_lsb] = trig[idx];
      rd_word[mode_msb:mode_lsb] = mode[idx];
      rd_word[ctl_msb:ctl_lsb]   = ctl[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready  <= 1'b0;
      rdata  <= '0;
      nvbits <= 1'b0;
      nlbits <= '0;
      nmbits <= '0;
      for (int i = 0; i < num_irq; i++) begin
        ie[i]   <= 1'b0;
        shv[i]  <= 1'b0;
        trig[i] <= trig_level;
        mode[i] <= '0;
        ctl[i]  <= ctl_fill;
      end
    end else begin
      ready <= valid && (is_cfg || is_info || is_int);
      rdata <= (valid && is_read) ? rd_word : '0;
      if (valid && !is_read) begin
        if (is_cfg && wstrb[0]) begin
          nvbits <= wdata[cfg_nvbits_bit];
          nlbits <= wdata[cfg_nlbits_msb:cfg_nlbits_lsb];
          nmbits <= wdata[cfg_nmbits_msb:cfg_nmbits_lsb];
        end
        if (is_int) begin
          if (wstrb[1]) begin
            ie[idx] <= wdata[ie_bit];
          end
          if (wstrb[2]) begin
            shv[idx]  <= wdata[shv_bit];
            trig[idx] <= trig_mode_t'(wdata[trig_msb:trig_lsb]);
            mode[idx] <= wdata[mode_msb:mode_lsb];
          end
          if (wstrb[3]) begin
            ctl[idx] <= wdata[ctl_msb:ctl_lsb] | ctl_fill;
          end
        end
      end
    end
  end

endmodule

//--- common/clic_regmap_pkg.sv
package clic_regmap_pkg;

  // region offsets.
  localparam logic [31:0] cfg_addr  = 32'd0;
  localparam logic [31:0] info_addr = 32'd4;
  localparam logic [31:0] int_base  = 32'd4096;

  // per-interrupt word, 4 bytes per interrupt.
  localparam int ip_bit   = 0;
  localparam int ie_bit   = 8;
  localparam int shv_bit  = 16;
  localparam int trig_lsb = 17;
  localparam int trig_msb = 18;
  localparam int mode_lsb = 22;
  localparam int mode_msb = 23;
  localparam int ctl_lsb  = 24;
  localparam int ctl_msb  = 31;

  // configuration word.
  localparam int cfg_nvbits_bit = 0;
  localparam int cfg_nlbits_lsb = 1;
  localparam int cfg_nlbits_msb = 4;
  localparam int cfg_nmbits_lsb = 5;
  localparam int cfg_nmbits_msb = 6;

  // information word, read only.
  localparam int info_ctlbits_lsb = 21;
  localparam int info_ctlbits_msb = 24;
  localparam int info_numirq_lsb  = 0;
  localparam int info_numirq_msb  = 12;

endpackage

//--- common/clic_types_pkg.sv
package clic_types_pkg;

  // interrupt index and the ID reported to the core.
  typedef logic [11:0] irq_id_t;

  // per-interrupt control byte.
  typedef logic [7:0] ctl_t;

  // decoded level and priority.
  typedef logic [7:0] level_t;
  typedef logic [7:0] prio_t;

  // number of level bits from the configuration word.
  typedef logic [3:0] nlbits_t;

  // bit 0 marks an edge mode, bit 1 selects the falling edge.
  typedef enum logic [1:0] {
    trig_level    = 2'b00,
    trig_pos_edge = 2'b01,
    trig_neg_edge = 2'b11
  } trig_mode_t;

  // bus side.
  typedef logic [31:0] bus_word_t;
  typedef logic [31:0] bus_addr_t;
  typedef logic [3:0]  wstrb_t;

endpackage
